//--- source/isi_chan_pkg.sv
package isi_chan_pkg;

    // pam-4 symbol on the input and decision side, 0 to 3
    typedef logic [1:0] symbol_t;

    // signed channel voltage at mapper, channel and slicer
    typedef logic signed [7:0] sample_t;

    // partial sum of the transposed tap chain
    // headroom over sample_t for a few taps
    typedef logic signed [11:0] acc_t;

    // tap weight is mantissa * 2^-shift
    typedef logic signed [7:0] tap_coeff_t;
    typedef logic [2:0] tap_shift_t;

    // apb byte address and data word
    typedef logic [11:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // control register, bit 0 enables the channel
    localparam apb_addr_t ctrl_offset = 12'h000;
    localparam int ctrl_enable_bit = 0;

    // tap k lives at tap_base_offset + 4*k
    localparam apb_addr_t tap_base_offset = 12'h010;

    // tap word layout
    // mantissa in 7:0, shift count in 10:8
    localparam int tap_coeff_lsb = 0;
    localparam int tap_shift_lsb = 8;

    // slicer fill state
    // streaming while chan_valid arrives back to back
    typedef enum logic {
        slicer_idle,
        slicer_streaming
    } slicer_state_e;

endpackage

//--- source/apb_tap_regs.sv
`timescale 1ns/1ps

module apb_tap_regs #(
    parameter int TAP_COUNT = 3
) (
    input  logic                                      clk,
    input  logic                                      rstn,
    input  logic                                      psel,
    input  logic                                      penable,
    input  logic                                      pwrite,
    input  isi_chan_pkg::apb_addr_t                   paddr,
    input  isi_chan_pkg::apb_data_t                   pwdata,
    output isi_chan_pkg::apb_data_t                   prdata,
    output logic                                      pready,
    output logic                                      pslverr,
    output logic                                      chan_enable,
    output isi_chan_pkg::tap_coeff_t [TAP_COUNT-1:0]  tap_coeff,
    output isi_chan_pkg::tap_shift_t [TAP_COUNT-1:0]  tap_shift
);

    localparam int coeff_w = $bits(isi_chan_pkg::tap_coeff_t);
    localparam int shift_w = $bits(isi_chan_pkg::tap_shift_t);

    isi_chan_pkg::apb_addr_t tap_off;
    logic [9:0]              tap_idx;
    logic                    ctrl_hit;
    logic                    tap_hit;
    logic                    addr_ok;
    logic                    wr_en;

    // address decode
    always_comb begin
        tap_off  = paddr - isi_chan_pkg::tap_base_offset;
        // word index above the tap base
        tap_idx  = tap_off[11:2];
        ctrl_hit = (paddr == isi_chan_pkg::ctrl_offset);
        // word aligned, not below the base, and inside the tap array
        tap_hit  = (paddr >= isi_chan_pkg::tap_base_offset) &&
                   (tap_off[1:0] == 2'b00) &&
                   (int'(tap_idx) < TAP_COUNT);
        addr_ok  = ctrl_hit || tap_hit;
    end

    // no wait states, every transfer ends in its access phase
    assign pready  = 1'b1;
    // error only while the access phase is on the bus
    assign pslverr = psel && penable && !addr_ok;
    // bad addresses never write
    assign wr_en   = psel && penable && pwrite && addr_ok;

    // config registers
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            chan_enable <= 1'b0;
            tap_coeff   <= '0;
            tap_shift   <= '0;
        end else if (wr_en) begin
            if (ctrl_hit) begin
                chan_enable <= pwdata[isi_chan_pkg::ctrl_enable_bit];
            end
            for (int k = 0; k < TAP_COUNT; k++) begin
                if (tap_hit && (int'(tap_idx) == k)) begin
                    tap_coeff[k] <= pwdata[isi_chan_pkg::tap_coeff_lsb +: coeff_w];
                    tap_shift[k] <= pwdata[isi_chan_pkg::tap_shift_lsb +: shift_w];
                end
            end
        end
    end

    // read mux, zero for anything unmapped
    always_comb begin
        prdata = '0;
        if (ctrl_hit) begin
            prdata[isi_chan_pkg::ctrl_enable_bit] = chan_enable;
        end else if (tap_hit) begin
            for (int k = 0; k < TAP_COUNT; k++) begin
                if (int'(tap_idx) == k) begin
                    prdata[isi_chan_pkg::tap_coeff_lsb +: coeff_w] = tap_coeff[k];
                    prdata[isi_chan_pkg::tap_shift_lsb +: shift_w] = tap_shift[k];
                end
            end
        end
    end

endmodule

//--- source/pam4_symbol_mapper.sv
`timescale 1ns/1ps

module pam4_symbol_mapper #(
    parameter int SYMBOL_SEP = 32
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  isi_chan_pkg::symbol_t   sym_in,
    input  logic                    sym_valid,
    input  logic                    chan_enable,
    output isi_chan_pkg::sample_t   level,
    output logic                    level_valid
);

    isi_chan_pkg::sample_t mapped;
    logic                  accept;

    // symbols offered while disabled are dropped
    assign accept = sym_valid && chan_enable;

    // level = (2s - 3) * sep / 2
    // sep 32 gives -48, -16, 16, 48
    always_comb begin
        mapped = isi_chan_pkg::sample_t'(((2 * int'(sym_in)) - 3) * SYMBOL_SEP / 2);
    end

    // valid flag, one cycle behind sym_valid
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            level_valid <= 1'b0;
        end else begin
            level_valid <= accept;
        end
    end

    // level payload
    // only loaded on accepted symbols
    always_ff @(posedge clk) begin
        if (accept) begin
            level <= mapped;
        end
    end

endmodule

//--- source/isi_channel.sv
`timescale 1ns/1ps

module isi_channel #(
    parameter int TAP_COUNT = 3
) (
    input  logic                                      clk,
    input  logic                                      rstn,
    input  isi_chan_pkg::sample_t                     level,
    input  logic                                      level_valid,
    input  logic                                      chan_enable,
    input  isi_chan_pkg::tap_coeff_t [TAP_COUNT-1:0]  tap_coeff,
    input  isi_chan_pkg::tap_shift_t [TAP_COUNT-1:0]  tap_shift,
    output isi_chan_pkg::sample_t                     chan_sample,
    output logic                                      chan_valid
);

    localparam int acc_w   = $bits(isi_chan_pkg::acc_t);
    localparam int acc_max = (1 << (acc_w - 1)) - 1;
    localparam int acc_min = -(1 << (acc_w - 1));
    localparam int smp_w   = $bits(isi_chan_pkg::sample_t);
    localparam int smp_max = (1 << (smp_w - 1)) - 1;
    localparam int smp_min = -(1 << (smp_w - 1));

    // clip to the partial sum range
    function automatic isi_chan_pkg::acc_t clamp_acc(input int v);
        if (v > acc_max) begin
            return isi_chan_pkg::acc_t'(acc_max);
        end else if (v < acc_min) begin
            return isi_chan_pkg::acc_t'(acc_min);
        end
        return isi_chan_pkg::acc_t'(v);
    endfunction

    // clip to the sample range
    function automatic isi_chan_pkg::sample_t clamp_sample(input int v);
        if (v > smp_max) begin
            return isi_chan_pkg::sample_t'(smp_max);
        end else if (v < smp_min) begin
            return isi_chan_pkg::sample_t'(smp_min);
        end
        return isi_chan_pkg::sample_t'(v);
    endfunction

    // weighted level per tap
    isi_chan_pkg::acc_t prod [TAP_COUNT];
    // next value of each partial sum
    isi_chan_pkg::acc_t nxt  [TAP_COUNT];
    // registered partial sums, psum[0] is the head
    isi_chan_pkg::acc_t psum [TAP_COUNT];

    // level * mantissa, then arithmetic shift right
    // int math keeps the sign through the shift (floor)
    always_comb begin
        for (int k = 0; k < TAP_COUNT; k++) begin
            prod[k] = clamp_acc((int'(level) * int'($signed(tap_coeff[k]))) >>> tap_shift[k]);
        end
    end

    // transposed form
    // last tap starts the tail, earlier taps add onto the later sum
    always_comb begin
        nxt[TAP_COUNT-1] = prod[TAP_COUNT-1];
        for (int k = 0; k < TAP_COUNT - 1; k++) begin
            nxt[k] = clamp_acc(int'(prod[k]) + int'(psum[k+1]));
        end
    end

    // chain advances once per valid level
    // history wiped while the channel is off
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            psum       <= '{default: '0};
            chan_valid <= 1'b0;
        end else if (!chan_enable) begin
            psum       <= '{default: '0};
            chan_valid <= 1'b0;
        end else begin
            chan_valid <= level_valid;
            if (level_valid) begin
                for (int k = 0; k < TAP_COUNT; k++) begin
                    psum[k] <= nxt[k];
                end
            end
        end
    end

    // head sum squeezed into the sample range
    assign chan_sample = clamp_sample(int'(psum[0]));

endmodule

//--- source/pam4_slicer.sv
`timescale 1ns/1ps

module pam4_slicer #(
    parameter int SYMBOL_SEP = 32
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  isi_chan_pkg::sample_t   chan_sample,
    input  logic                    chan_valid,
    output isi_chan_pkg::sample_t   sample_out,
    output isi_chan_pkg::symbol_t   sym_out,
    output logic                    out_valid
);

    isi_chan_pkg::slicer_state_e state;
    isi_chan_pkg::symbol_t       decision;

    // three thresholds, midway between adjacent levels
    always_comb begin
        if (int'(chan_sample) < -SYMBOL_SEP) begin
            decision = 2'd0;
        end else if (int'(chan_sample) < 0) begin
            decision = 2'd1;
        end else if (int'(chan_sample) < SYMBOL_SEP) begin
            decision = 2'd2;
        end else begin
            decision = 2'd3;
        end
    end

    // fill state
    // any gap in chan_valid drops back to idle
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= isi_chan_pkg::slicer_idle;
        end else if (chan_valid) begin
            state <= isi_chan_pkg::slicer_streaming;
        end else begin
            state <= isi_chan_pkg::slicer_idle;
        end
    end

    // sample and decision held until the next valid
    always_ff @(posedge clk) begin
        if (chan_valid) begin
            sample_out <= chan_sample;
            sym_out    <= decision;
        end
    end

    // output is valid one cycle after each channel sample
    assign out_valid = (state == isi_chan_pkg::slicer_streaming);

endmodule

//--- source/isi_link_top.sv
`timescale 1ns/1ps

module isi_link_top #(
    parameter int TAP_COUNT  = 3,
    parameter int SYMBOL_SEP = 32
) (
    input  logic                      clk,
    input  logic                      rstn,
    // apb config port
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  isi_chan_pkg::apb_addr_t   paddr,
    input  isi_chan_pkg::apb_data_t   pwdata,
    output isi_chan_pkg::apb_data_t   prdata,
    output logic                      pready,
    output logic                      pslverr,
    // symbol stream in
    input  isi_chan_pkg::symbol_t     sym_in,
    input  logic                      sym_valid,
    // decided stream out, 3 cycles behind sym_valid
    output isi_chan_pkg::sample_t     sample_out,
    output isi_chan_pkg::symbol_t     sym_out,
    output logic                      out_valid
);

    logic                                     chan_enable;
    isi_chan_pkg::tap_coeff_t [TAP_COUNT-1:0] tap_coeff;
    isi_chan_pkg::tap_shift_t [TAP_COUNT-1:0] tap_shift;
    isi_chan_pkg::sample_t                    level;
    logic                                     level_valid;
    isi_chan_pkg::sample_t                    chan_sample;
    logic                                     chan_valid;

    // enable and tap registers
    apb_tap_regs #(
        .TAP_COUNT (TAP_COUNT)
    ) i_regs (
        .clk         (clk),
        .rstn        (rstn),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .chan_enable (chan_enable),
        .tap_coeff   (tap_coeff),
        .tap_shift   (tap_shift)
    );

    // symbol to level
    pam4_symbol_mapper #(
        .SYMBOL_SEP (SYMBOL_SEP)
    ) i_mapper (
        .clk         (clk),
        .rstn        (rstn),
        .sym_in      (sym_in),
        .sym_valid   (sym_valid),
        .chan_enable (chan_enable),
        .level       (level),
        .level_valid (level_valid)
    );

    // isi convolution
    isi_channel #(
        .TAP_COUNT (TAP_COUNT)
    ) i_channel (
        .clk         (clk),
        .rstn        (rstn),
        .level       (level),
        .level_valid (level_valid),
        .chan_enable (chan_enable),
        .tap_coeff   (tap_coeff),
        .tap_shift   (tap_shift),
        .chan_sample (chan_sample),
        .chan_valid  (chan_valid)
    );

    // decision
    pam4_slicer #(
        .SYMBOL_SEP (SYMBOL_SEP)
    ) i_slicer (
        .clk         (clk),
        .rstn        (rstn),
        .chan_sample (chan_sample),
        .chan_valid  (chan_valid),
        .sample_out  (sample_out),
        .sym_out     (sym_out),
        .out_valid   (out_valid)
    );

endmodule

//--- verif/isi_link_tb.sv
`timescale 1ns/1ps

module isi_link_tb;

    localparam int sep        = 32;
    localparam int taps       = 3;
    localparam int drive_dly  = 2;
    localparam int wait_limit = 20;

    logic                    clk = 1'b0;
    logic                    rstn;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    isi_chan_pkg::apb_addr_t paddr;
    isi_chan_pkg::apb_data_t pwdata;
    isi_chan_pkg::apb_data_t prdata;
    logic                    pready;
    logic                    pslverr;
    isi_chan_pkg::symbol_t   sym_in;
    logic                    sym_valid;
    isi_chan_pkg::sample_t   sample_out;
    isi_chan_pkg::symbol_t   sym_out;
    logic                    out_valid;

    int     errors = 0;
    int     checks = 0;
    int     cycle  = 0;
    integer seed   = 32'h3e2;

    // model taps, mirrored on every apb tap write
    int coeff_m [taps];
    int shift_m [taps];
    // accepted levels since the last enable, oldest first
    int hist [$];
    isi_chan_pkg::symbol_t stim [$];
    isi_chan_pkg::sample_t exp_smp [$];
    int sent_cycle [$];

    // 40 ns clock
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    isi_link_top i_dut (.*);

    task automatic check_sample(input string name, input isi_chan_pkg::sample_t got,
                                input isi_chan_pkg::sample_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_symbol(input string name, input isi_chan_pkg::symbol_t got,
                                input isi_chan_pkg::symbol_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_apb_data(input string name, input isi_chan_pkg::apb_data_t got,
                                  input isi_chan_pkg::apb_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // inputs change just after the rising edge
    task automatic step();
        @(posedge clk);
        #drive_dly;
    endtask

    function automatic isi_chan_pkg::apb_addr_t tap_addr(input int k);
        return isi_chan_pkg::tap_base_offset + isi_chan_pkg::apb_addr_t'(4 * k);
    endfunction

    // setup phase, then access phase until pready
    task automatic apb_access(input logic wr, input isi_chan_pkg::apb_addr_t addr,
                              input isi_chan_pkg::apb_data_t wdata,
                              output isi_chan_pkg::apb_data_t rdata, output logic err);
        int n;
        step();
        psel   = 1'b1;
        pwrite = wr;
        paddr  = addr;
        pwdata = wdata;
        step();
        penable = 1'b1;
        n = 0;
        @(negedge clk);
        while (!pready && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (!pready) begin
            errors++;
            $display("apb transfer to 0x%0h never saw pready", addr);
        end
        // sampled mid cycle, the transfer ends at the next edge
        rdata = prdata;
        err   = pslverr;
        step();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input isi_chan_pkg::apb_addr_t addr,
                             input isi_chan_pkg::apb_data_t data, output logic err);
        isi_chan_pkg::apb_data_t unused;
        apb_access(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input isi_chan_pkg::apb_addr_t addr,
                            output isi_chan_pkg::apb_data_t data, output logic err);
        apb_access(1'b0, addr, '0, data, err);
    endtask

    // mantissa in 7:0, shift in 10:8
    task automatic set_tap(input int k, input int c, input int s);
        logic err;
        apb_write(tap_addr(k), 32'((s << 8) | (c & 'hff)), err);
        check_flag("pslverr", err, 1'b0);
        coeff_m[k] = c;
        shift_m[k] = s;
    endtask

    // enabling restarts the channel history from zero
    task automatic set_enable(input logic en);
        logic err;
        apb_write(isi_chan_pkg::ctrl_offset, {31'd0, en}, err);
        check_flag("pslverr", err, 1'b0);
        if (en) begin
            hist.delete();
        end
    endtask

    // sum of floor(level * coeff / 2^shift) over the taps, then clipped
    function automatic isi_chan_pkg::sample_t model_sample();
        int sum;
        int n;
        sum = 0;
        n = hist.size();
        for (int k = 0; k < taps && k < n; k++) begin
            sum += (hist[n - 1 - k] * coeff_m[k]) >>> shift_m[k];
        end
        sum = (sum > 127) ? 127 : (sum < -128) ? -128 : sum;
        return isi_chan_pkg::sample_t'(sum);
    endfunction

    // thresholds at -sep, 0 and sep
    function automatic isi_chan_pkg::symbol_t model_decision(input int v);
        return (v < -sep) ? 2'd0 :
               (v < 0)    ? 2'd1 :
               (v < sep)  ? 2'd2 : 2'd3;
    endfunction

    // back to back symbols from stim, outputs checked as they come out
    task automatic send_stream(input bit check_lat);
        int total;
        total = stim.size();
        exp_smp.delete();
        sent_cycle.delete();
        fork
            begin
                for (int i = 0; i < total; i++) begin
                    step();
                    sym_in    = stim[i];
                    sym_valid = 1'b1;
                    hist.push_back((2 * int'(stim[i]) - 3) * (sep / 2));
                    exp_smp.push_back(model_sample());
                    sent_cycle.push_back(cycle);
                end
                step();
                sym_valid = 1'b0;
            end
            begin
                for (int i = 0; i < total; i++) begin
                    int n;
                    isi_chan_pkg::sample_t e;
                    n = 0;
                    @(negedge clk);
                    while (!out_valid && n < wait_limit) begin
                        @(negedge clk);
                        n++;
                    end
                    if (!out_valid) begin
                        errors++;
                        $display("no out_valid for symbol %0d of the stream", i);
                        break;
                    end
                    e = exp_smp.pop_front();
                    check_sample("sample_out", sample_out, e);
                    check_symbol("sym_out", sym_out, model_decision(int'(e)));
                    // symbol driven in cycle n comes out in cycle n+3
                    if (check_lat && (cycle - sent_cycle[i] != 3)) begin
                        errors++;
                        $display("symbol %0d came out %0d cycles after it was sent",
                                 i, cycle - sent_cycle[i]);
                    end
                end
            end
        join
        stim.delete();
    endtask

    // symbols offered while disabled, out_valid must stay low
    task automatic send_dropped(input int count);
        int seen;
        seen = 0;
        for (int i = 0; i < count + 4; i++) begin
            step();
            sym_in    = isi_chan_pkg::symbol_t'($random(seed));
            sym_valid = (i < count);
            @(negedge clk);
            if (out_valid) begin
                seen++;
            end
        end
        checks++;
        if (seen != 0) begin
            errors++;
            $display("out_valid rose %0d times while the channel was disabled", seen);
        end
    endtask

    task automatic add_random(input int count);
        for (int i = 0; i < count; i++) begin
            stim.push_back(isi_chan_pkg::symbol_t'($random(seed)));
        end
    endtask

    task automatic report(input string name, input int errs_before);
        $display("test %s: %s", name, (errors == errs_before) ? "ok" : "failed");
    endtask

    task automatic test_regs();
        isi_chan_pkg::apb_data_t wdata [taps];
        isi_chan_pkg::apb_data_t rdata;
        logic err;
        int start;
        start = errors;
        for (int k = 0; k < taps; k++) begin
            wdata[k] = $random(seed);
            apb_write(tap_addr(k), wdata[k], err);
        end
        // only mantissa and shift bits are kept
        for (int k = 0; k < taps; k++) begin
            apb_read(tap_addr(k), rdata, err);
            check_apb_data("prdata", rdata, wdata[k] & 32'h7ff);
            check_flag("pslverr", err, 1'b0);
        end
        // first word past the last tap
        apb_write(tap_addr(taps), 32'h7ff, err);
        check_flag("pslverr", err, 1'b1);
        apb_read(tap_addr(taps), rdata, err);
        check_flag("pslverr", err, 1'b1);
        check_apb_data("prdata", rdata, '0);
        // last tap untouched by the rejected write
        apb_read(tap_addr(taps - 1), rdata, err);
        check_apb_data("prdata", rdata, wdata[taps - 1] & 32'h7ff);
        set_enable(1'b1);
        apb_read(isi_chan_pkg::ctrl_offset, rdata, err);
        check_apb_data("prdata", rdata, 32'h1);
        set_enable(1'b0);
        report("register access", start);
    endtask

    task automatic test_identity();
        int start;
        start = errors;
        set_tap(0, 1, 0);
        set_tap(1, 0, 0);
        set_tap(2, 0, 0);
        set_enable(1'b1);
        stim = '{0, 1, 2, 3, 3, 2, 1, 0};
        add_random(8);
        send_stream(1'b1);
        set_enable(1'b0);
        report("identity channel", start);
    endtask

    task automatic test_isi();
        int start;
        start = errors;
        set_tap(0, 64, 6);
        set_tap(1, 32, 6);
        set_tap(2, -16, 6);
        set_enable(1'b1);
        add_random(24);
        send_stream(1'b0);
        set_enable(1'b0);
        report("isi convolution", start);
    endtask

    task automatic test_saturation();
        int start;
        start = errors;
        // peaks well past the sample range and past the partial sum range
        set_tap(0, 40, 0);
        set_tap(1, 20, 1);
        set_tap(2, -24, 0);
        set_enable(1'b1);
        stim = '{3, 3, 3, 0, 0, 0};
        add_random(16);
        send_stream(1'b0);
        set_enable(1'b0);
        // level differences land exactly on -sep, 0 and sep
        set_tap(0, 1, 0);
        set_tap(1, -1, 0);
        set_tap(2, 0, 0);
        set_enable(1'b1);
        stim = '{1, 1, 2, 1, 0, 1, 2, 3, 2};
        add_random(12);
        send_stream(1'b0);
        set_enable(1'b0);
        report("saturation and decisions", start);
    endtask

    task automatic test_gating();
        int start;
        start = errors;
        set_tap(0, 64, 6);
        set_tap(1, 32, 6);
        set_tap(2, -16, 6);
        set_enable(1'b1);
        add_random(4);
        send_stream(1'b0);
        set_enable(1'b0);
        send_dropped(5);
        // history must restart from zero
        set_enable(1'b1);
        add_random(6);
        send_stream(1'b0);
        set_enable(1'b0);
        report("enable gating", start);
    endtask

    initial begin
        rstn      = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        sym_in    = '0;
        sym_valid = 1'b0;
        repeat (8) @(posedge clk);
        #drive_dly;
        rstn = 1'b1;
        test_regs();
        test_identity();
        test_isi();
        test_saturation();
        test_gating();
        $display("tests 5, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
source/isi_chan_pkg.sv
source/apb_tap_regs.sv
source/pam4_symbol_mapper.sv
source/isi_channel.sv
source/pam4_slicer.sv
source/isi_link_top.sv
verif/isi_link_tb.sv

//--- Bender.yml
package:
  name: isi_link

sources:
  - source/isi_chan_pkg.sv
  - source/apb_tap_regs.sv
  - source/pam4_symbol_mapper.sv
  - source/isi_channel.sv
  - source/pam4_slicer.sv
  - source/isi_link_top.sv
  - target: test
    files:
      - verif/isi_link_tb.sv
